//--- lj_cfg_pkg.sv
// force tile APB map
// region select from the upper address bits, word index below it
// control and status bit positions
package lj_cfg_pkg;

	localparam int apb_addr_w = 14;
	localparam int apb_data_w = 32;
	localparam int region_lsb = 12; // paddr[13:12] picks the region
	localparam int region_w = 2;
	localparam int idx_lsb = 2; // word aligned index inside a region
	localparam int idx_w = 10;

	typedef enum logic [region_w-1:0] {
		region_reg = 2'd0, // ctrl and status
		region_ref = 2'd1, // reference positions
		region_nbr = 2'd2, // neighbor positions
		region_coef = 2'd3 // c0/c1 table
	} apb_region_e;

	localparam logic [region_lsb-1:0] ctrl_off = 12'h000;
	localparam logic [region_lsb-1:0] stat_off = 12'h004;
	localparam int ctrl_start_bit = 0;
	localparam int stat_busy_bit = 0;
	localparam int stat_done_bit = 1;

endpackage

//--- lj_num_pkg.sv
// number formats of the force tile
// signed fixed point positions, coefficients and forces
// plus the pair sequencer states
package lj_num_pkg;

	localparam int pos_w = 10;
	localparam int pos_word_w = 3 * pos_w; // x 29:20, y 19:10, z 9:0
	localparam int disp_w = pos_w + 1; // difference of two positions
	localparam int coef_w = 16;
	localparam int r2_w = 20;
	localparam int frac_w = 8;
	localparam int force_w = 32;

	typedef logic signed [pos_w-1:0] pos_t;
	typedef logic signed [disp_w-1:0] disp_t;
	typedef logic signed [coef_w-1:0] coef_t; // c0 in 31:16, c1 in 15:0 of a table word
	typedef logic [r2_w-1:0] r2_t;
	typedef logic signed [force_w-1:0] force_t;

	typedef enum logic [1:0] {
		seq_idle,
		seq_run, // one pair read per cycle
		seq_drain // last read still in the register stage
	} seq_state_e;

endpackage

//--- lj_pipe_if.sv
// internal streams of the force tile
// RAM write requests, pair stream and force stream, valid only
`timescale 1ns/100ps

interface lj_wr_if;
	logic we; // one word per cycle, no reply
	lj_cfg_pkg::apb_region_e region;
	logic [lj_cfg_pkg::idx_w-1:0] addr; // word index
	logic [lj_cfg_pkg::apb_data_w-1:0] data;

	modport master (output we, region, addr, data);
	modport slave (input we, region, addr, data);
endinterface

interface lj_pair_if #(parameter int REF_IW = 2);
	logic valid;
	logic [REF_IW-1:0] ref_idx;
	logic last; // final neighbor of this reference
	lj_num_pkg::disp_t dx;
	lj_num_pkg::disp_t dy;
	lj_num_pkg::disp_t dz;
	lj_num_pkg::r2_t r2; // saturated

	modport source (output valid, ref_idx, last, dx, dy, dz, r2);
	modport sink (input valid, ref_idx, last, dx, dy, dz, r2);
endinterface

interface lj_force_if #(parameter int REF_IW = 2);
	logic valid;
	logic keep; // pair passed the cutoff/self filter
	logic [REF_IW-1:0] ref_idx;
	logic last;
	lj_num_pkg::force_t fx;
	lj_num_pkg::force_t fy;
	lj_num_pkg::force_t fz;

	modport source (output valid, keep, ref_idx, last, fx, fy, fz);
	modport sink (input valid, keep, ref_idx, last, fx, fy, fz);
endinterface

//--- lj_apb_loader.sv
// APB slave of the force tile
// turns writes into RAM write requests, holds start, busy and done
`timescale 1ns/100ps

module lj_apb_loader #(
	parameter int REF_PARTICLE_NUM = 4,
	parameter int NEIGHBOR_PARTICLE_NUM = 6,
	parameter int SEGMENT_NUM = 8,
	parameter int BIN_WIDTH = 3
) (
	input  logic clk,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [lj_cfg_pkg::apb_addr_w-1:0] paddr,
	input  logic [lj_cfg_pkg::apb_data_w-1:0] pwdata,
	output logic [lj_cfg_pkg::apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic start,
	input  logic done,
	lj_wr_if.master wr
);
	localparam int TBL_NUM = SEGMENT_NUM << BIN_WIDTH; // coefficient words

	lj_cfg_pkg::apb_region_e region;
	logic [lj_cfg_pkg::region_lsb-1:0] offset;
	logic [lj_cfg_pkg::idx_w-1:0] idx;
	logic access, bad_addr, busy_err, start_req;
	logic busy, done_flag;

	assign region = lj_cfg_pkg::apb_region_e'(
		paddr[lj_cfg_pkg::region_lsb +: lj_cfg_pkg::region_w]);
	assign offset = paddr[lj_cfg_pkg::region_lsb-1:0];
	assign idx = paddr[lj_cfg_pkg::idx_lsb +: lj_cfg_pkg::idx_w];
	assign access = psel && penable; // access phase, zero wait
	assign pready = 1'b1;

	always_comb begin
		case (region)
			lj_cfg_pkg::region_ref: bad_addr = int'(idx) >= REF_PARTICLE_NUM;
			lj_cfg_pkg::region_nbr: bad_addr = int'(idx) >= NEIGHBOR_PARTICLE_NUM;
			lj_cfg_pkg::region_coef: bad_addr = int'(idx) >= TBL_NUM;
			default: bad_addr = offset != lj_cfg_pkg::ctrl_off && offset != lj_cfg_pkg::stat_off;
		endcase
	end

	// RAMs are frozen from the start pulse until done
	assign busy_err = pwrite && region != lj_cfg_pkg::region_reg && (busy || start);
	assign pslverr = access && (bad_addr || busy_err);
	assign start_req = access && pwrite && region == lj_cfg_pkg::region_reg &&
		offset == lj_cfg_pkg::ctrl_off && pwdata[lj_cfg_pkg::ctrl_start_bit];

	assign wr.we = access && pwrite && region != lj_cfg_pkg::region_reg && !pslverr;
	assign wr.region = region;
	assign wr.addr = idx;
	assign wr.data = pwdata;

	always_comb begin
		prdata = '0;
		if (access && !pwrite && region == lj_cfg_pkg::region_reg) begin
			if (offset == lj_cfg_pkg::stat_off) begin
				prdata[lj_cfg_pkg::stat_busy_bit] = busy;
				prdata[lj_cfg_pkg::stat_done_bit] = done_flag;
			end else if (offset == lj_cfg_pkg::ctrl_off) begin
				// start reads back while running
				prdata[lj_cfg_pkg::ctrl_start_bit] = busy || start;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			start <= 1'b0;
			busy <= 1'b0;
			done_flag <= 1'b0;
		end else begin
			start <= start_req && !busy && !start; // restart ignored mid run
			if (start)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
			if (start)
				done_flag <= 1'b0;
			else if (done)
				done_flag <= 1'b1; // sticky until next start
		end
	end

	// completion from the accumulator only inside a run
	assert property (@(posedge clk) disable iff (!rst_n) done |-> busy);

endmodule

//--- lj_pair_gen.sv
// pair generator
// reference and neighbor position RAMs, walks every ref x neighbor pair
// and emits dx, dy, dz and saturated r2 one pair per cycle
`timescale 1ns/100ps

module lj_pair_gen #(
	parameter int REF_PARTICLE_NUM = 4,
	parameter int NEIGHBOR_PARTICLE_NUM = 6,
	localparam int REF_IW = (REF_PARTICLE_NUM > 1) ? $clog2(REF_PARTICLE_NUM) : 1
) (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	lj_wr_if.slave wr,
	lj_pair_if.source pair
);
	localparam int NBR_IW = (NEIGHBOR_PARTICLE_NUM > 1) ? $clog2(NEIGHBOR_PARTICLE_NUM) : 1;
	localparam int PW = lj_num_pkg::pos_w;
	localparam int RW = lj_num_pkg::r2_w;

	logic [lj_num_pkg::pos_word_w-1:0] ref_ram [REF_PARTICLE_NUM];
	logic [lj_num_pkg::pos_word_w-1:0] nbr_ram [NEIGHBOR_PARTICLE_NUM];
	logic [lj_num_pkg::pos_word_w-1:0] ref_word, nbr_word;
	lj_num_pkg::seq_state_e state;
	logic [REF_IW-1:0] ref_cnt, rd_ref;
	logic [NBR_IW-1:0] nbr_cnt;
	logic issue, nbr_end, last_pair, rd_valid, rd_last;
	lj_num_pkg::disp_t dx, dy, dz;
	logic [RW+1:0] sq_sum; // three squares of 11 bit values

	always_ff @(posedge clk) begin
		if (wr.we && wr.region == lj_cfg_pkg::region_ref)
			ref_ram[wr.addr[REF_IW-1:0]] <= wr.data[lj_num_pkg::pos_word_w-1:0];
		if (wr.we && wr.region == lj_cfg_pkg::region_nbr)
			nbr_ram[wr.addr[NBR_IW-1:0]] <= wr.data[lj_num_pkg::pos_word_w-1:0];
	end

	assign nbr_end = nbr_cnt == NBR_IW'(NEIGHBOR_PARTICLE_NUM - 1);
	assign last_pair = nbr_end && ref_cnt == REF_IW'(REF_PARTICLE_NUM - 1);
	assign issue = (state == lj_num_pkg::seq_idle && start) || state == lj_num_pkg::seq_run;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= lj_num_pkg::seq_idle;
			ref_cnt <= '0;
			nbr_cnt <= '0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= issue;
			case (state)
				lj_num_pkg::seq_idle:
					if (start)
						state <= last_pair ? lj_num_pkg::seq_drain : lj_num_pkg::seq_run;
				lj_num_pkg::seq_run: if (last_pair) state <= lj_num_pkg::seq_drain;
				default: if (!rd_valid) state <= lj_num_pkg::seq_idle; // last word registered
			endcase
			if (issue) begin
				nbr_cnt <= nbr_end ? '0 : nbr_cnt + 1'b1; // neighbor index runs inside ref index
				if (nbr_end)
					ref_cnt <= last_pair ? '0 : ref_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		ref_word <= ref_ram[ref_cnt]; // read issued in the start cycle already
		nbr_word <= nbr_ram[nbr_cnt];
		rd_ref <= ref_cnt;
		rd_last <= nbr_end;
	end

	assign dx = lj_num_pkg::pos_t'(ref_word[2*PW +: PW]) - lj_num_pkg::pos_t'(nbr_word[2*PW +: PW]);
	assign dy = lj_num_pkg::pos_t'(ref_word[PW +: PW]) - lj_num_pkg::pos_t'(nbr_word[PW +: PW]);
	assign dz = lj_num_pkg::pos_t'(ref_word[0 +: PW]) - lj_num_pkg::pos_t'(nbr_word[0 +: PW]);
	assign sq_sum = dx * dx + dy * dy + dz * dz;

	always_ff @(posedge clk) begin
		if (!rst_n)
			pair.valid <= 1'b0;
		else
			pair.valid <= rd_valid;
		pair.ref_idx <= rd_ref;
		pair.last <= rd_last;
		pair.dx <= dx;
		pair.dy <= dy;
		pair.dz <= dz;
		pair.r2 <= (|sq_sum[RW+1:RW]) ? '1 : sq_sum[RW-1:0]; // clamp, always beyond cutoff
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		state == lj_num_pkg::seq_idle |-> !pair.valid);
	// position RAMs stay frozen while the walk reads them
	assert property (@(posedge clk) disable iff (!rst_n)
		state != lj_num_pkg::seq_idle |-> !(wr.we &&
		(wr.region == lj_cfg_pkg::region_ref || wr.region == lj_cfg_pkg::region_nbr)));

endmodule

//--- lj_force_pipe.sv
// force pipeline, four stages
// filter plus segment/bin/frac split, coefficient read,
// f = c0 + ((c1 * frac) >>> 8), then (f * d) >>> 8 per axis
`timescale 1ns/100ps

module lj_force_pipe #(
	parameter int SEGMENT_NUM = 8,
	parameter int BIN_WIDTH = 3,
	parameter lj_num_pkg::r2_t CUTOFF_2 = 20'd40000,
	parameter int REF_IW = 2
) (
	input  logic clk,
	input  logic rst_n,
	lj_wr_if.slave wr,
	lj_pair_if.sink pair,
	lj_force_if.source frc
);
	localparam int RW = lj_num_pkg::r2_w;
	localparam int FW = lj_num_pkg::frac_w;
	localparam int SEG_W = (SEGMENT_NUM > 1) ? $clog2(SEGMENT_NUM) : 1;
	localparam int TBL_AW = SEG_W + BIN_WIDTH;
	localparam int SEG_LO = $clog2(CUTOFF_2) - SEGMENT_NUM; // lead-one position of segment 0

	typedef struct packed {
		logic keep;
		logic last;
		logic [REF_IW-1:0] ref_idx;
		lj_num_pkg::disp_t dx;
		lj_num_pkg::disp_t dy;
		lj_num_pkg::disp_t dz;
	} side_t;

	logic [lj_cfg_pkg::apb_data_w-1:0] coef_ram [2**TBL_AW];
	logic [lj_cfg_pkg::apb_data_w-1:0] coef_q; // c0 high half, c1 low half
	side_t side_q [1:3];
	logic [1:3] vld_q;
	logic [4:0] lead, p_eff, s1_seg;
	lj_num_pkg::r2_t mant;
	logic [BIN_WIDTH-1:0] s1_bin;
	logic [FW-1:0] s1_frac, s2_frac;
	logic signed [lj_num_pkg::coef_w+FW:0] prod;
	lj_num_pkg::force_t s3_f;

	always_ff @(posedge clk) begin
		if (wr.we && wr.region == lj_cfg_pkg::region_coef)
			coef_ram[wr.addr[TBL_AW-1:0]] <= wr.data;
	end

	always_comb begin
		lead = '0;
		for (int i = 0; i < RW; i++) begin
			if (pair.r2[i])
				lead = 5'(i);
		end
	end

	assign p_eff = (lead < 5'(SEG_LO)) ? 5'(SEG_LO) : lead; // short range folds into segment 0
	assign mant = pair.r2 << (5'(RW - 1) - p_eff); // leading one lands on the msb

	always_ff @(posedge clk) begin
		side_q[1].keep <= pair.r2 != '0 && pair.r2 < CUTOFF_2; // self pair and cutoff
		side_q[1].last <= pair.last;
		side_q[1].ref_idx <= pair.ref_idx;
		side_q[1].dx <= pair.dx;
		side_q[1].dy <= pair.dy;
		side_q[1].dz <= pair.dz;
		s1_seg <= p_eff - 5'(SEG_LO);
		s1_bin <= mant[RW-2 -: BIN_WIDTH]; // bits just below the leading one
		s1_frac <= mant[RW-2-BIN_WIDTH -: FW];
		coef_q <= coef_ram[{s1_seg[SEG_W-1:0], s1_bin}];
		s2_frac <= s1_frac;
		side_q[2] <= side_q[1];
		s3_f <= lj_num_pkg::coef_t'(coef_q[31:16]) + (prod >>> FW); // floor shift
		side_q[3] <= side_q[2];
		frc.fx <= (s3_f * side_q[3].dx) >>> FW;
		frc.fy <= (s3_f * side_q[3].dy) >>> FW;
		frc.fz <= (s3_f * side_q[3].dz) >>> FW;
		frc.keep <= side_q[3].keep;
		frc.last <= side_q[3].last; // filtered pairs still carry last
		frc.ref_idx <= side_q[3].ref_idx;
	end

	assign prod = lj_num_pkg::coef_t'(coef_q[15:0]) * $signed({1'b0, s2_frac});

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_q <= '0;
			frc.valid <= 1'b0;
		end else begin
			vld_q <= {pair.valid, vld_q[1:2]};
			frc.valid <= vld_q[3]; // fixed 4 cycle latency
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		vld_q[1] && side_q[1].keep |-> s1_seg < 5'(SEGMENT_NUM));

endmodule

//--- lj_force_accum.sv
// per reference force accumulator
// sums kept pair forces, publishes and clears on last,
// pulses done after the final reference
`timescale 1ns/100ps

module lj_force_accum #(
	parameter int REF_PARTICLE_NUM = 4,
	parameter int NEIGHBOR_PARTICLE_NUM = 6,
	localparam int REF_IW = (REF_PARTICLE_NUM > 1) ? $clog2(REF_PARTICLE_NUM) : 1
) (
	input  logic clk,
	input  logic rst_n,
	lj_force_if.sink frc,
	output lj_num_pkg::force_t force_x,
	output lj_num_pkg::force_t force_y,
	output lj_num_pkg::force_t force_z,
	output logic [REF_IW-1:0] force_ref,
	output logic force_valid,
	output logic done
);
	localparam int NBR_IW = (NEIGHBOR_PARTICLE_NUM > 1) ? $clog2(NEIGHBOR_PARTICLE_NUM) : 1;

	lj_num_pkg::force_t acc_x, acc_y, acc_z;
	lj_num_pkg::force_t add_x, add_y, add_z;
	logic [REF_IW-1:0] ref_cnt; // published references this run
	logic [NBR_IW-1:0] item_cnt; // items seen for current reference

	assign add_x = frc.keep ? frc.fx : '0; // filtered pairs add nothing
	assign add_y = frc.keep ? frc.fy : '0;
	assign add_z = frc.keep ? frc.fz : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc_x <= '0;
			acc_y <= '0;
			acc_z <= '0;
			item_cnt <= '0;
			ref_cnt <= '0;
			force_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			force_valid <= frc.valid && frc.last;
			done <= force_valid && ref_cnt == REF_IW'(REF_PARTICLE_NUM - 1);
			if (force_valid)
				ref_cnt <= (ref_cnt == REF_IW'(REF_PARTICLE_NUM - 1)) ? '0 : ref_cnt + 1'b1;
			if (frc.valid) begin
				acc_x <= frc.last ? '0 : acc_x + add_x; // clear for next reference
				acc_y <= frc.last ? '0 : acc_y + add_y;
				acc_z <= frc.last ? '0 : acc_z + add_z;
				item_cnt <= frc.last ? '0 : item_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frc.valid && frc.last) begin
			force_x <= acc_x + add_x; // includes the last item itself
			force_y <= acc_y + add_y;
			force_z <= acc_z + add_z;
			force_ref <= frc.ref_idx;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(force_valid && done));
	// last must close exactly one neighbor sweep
	assert property (@(posedge clk) disable iff (!rst_n)
		frc.valid && frc.last |-> item_cnt == NBR_IW'(NEIGHBOR_PARTICLE_NUM - 1));

endmodule

//--- lj_pipeline_top.sv
// LJ force tile top level
// APB loader, pair generator, force pipeline and accumulator
`timescale 1ns/100ps

module lj_pipeline_top #(
	parameter int REF_PARTICLE_NUM = 4,
	parameter int NEIGHBOR_PARTICLE_NUM = 6,
	parameter int SEGMENT_NUM = 8,
	parameter int BIN_WIDTH = 3,
	parameter lj_num_pkg::r2_t CUTOFF_2 = 20'd40000,
	localparam int REF_IW = (REF_PARTICLE_NUM > 1) ? $clog2(REF_PARTICLE_NUM) : 1
) (
	input  logic clk,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [lj_cfg_pkg::apb_addr_w-1:0] paddr,
	input  logic [lj_cfg_pkg::apb_data_w-1:0] pwdata,
	output logic [lj_cfg_pkg::apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output lj_num_pkg::force_t force_x,
	output lj_num_pkg::force_t force_y,
	output lj_num_pkg::force_t force_z,
	output logic [REF_IW-1:0] force_ref,
	output logic force_valid,
	output logic done
);
	logic start; // one cycle run trigger

	lj_wr_if wr_bus ();
	lj_pair_if #(.REF_IW(REF_IW)) pair_bus ();
	lj_force_if #(.REF_IW(REF_IW)) force_bus ();

	lj_apb_loader #(
		.REF_PARTICLE_NUM(REF_PARTICLE_NUM),
		.NEIGHBOR_PARTICLE_NUM(NEIGHBOR_PARTICLE_NUM),
		.SEGMENT_NUM(SEGMENT_NUM),
		.BIN_WIDTH(BIN_WIDTH)
	) i_apb_loader (
		.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .start(start), .done(done), .wr(wr_bus.master)
	);

	lj_pair_gen #(
		.REF_PARTICLE_NUM(REF_PARTICLE_NUM),
		.NEIGHBOR_PARTICLE_NUM(NEIGHBOR_PARTICLE_NUM)
	) i_pair_gen (
		.clk(clk), .rst_n(rst_n), .start(start), .wr(wr_bus.slave), .pair(pair_bus.source)
	);

	lj_force_pipe #(
		.SEGMENT_NUM(SEGMENT_NUM),
		.BIN_WIDTH(BIN_WIDTH),
		.CUTOFF_2(CUTOFF_2),
		.REF_IW(REF_IW)
	) i_force_pipe (
		.clk(clk), .rst_n(rst_n), .wr(wr_bus.slave), .pair(pair_bus.sink),
		.frc(force_bus.source)
	);

	lj_force_accum #(
		.REF_PARTICLE_NUM(REF_PARTICLE_NUM),
		.NEIGHBOR_PARTICLE_NUM(NEIGHBOR_PARTICLE_NUM)
	) i_force_accum (
		.clk(clk), .rst_n(rst_n), .frc(force_bus.sink), .force_x(force_x),
		.force_y(force_y), .force_z(force_z), .force_ref(force_ref),
		.force_valid(force_valid), .done(done)
	);

endmodule

//--- lj_pipeline_tb.sv
// testbench for the LJ force tile
// loads positions and coefficients over APB from the stim file,
// runs the tile twice and checks per reference forces and status
`timescale 1ns/100ps

module lj_pipeline_tb;
	localparam int REF_PARTICLE_NUM = 4;
	localparam int NEIGHBOR_PARTICLE_NUM = 6;
	localparam int SEGMENT_NUM = 8;
	localparam int BIN_WIDTH = 3;
	localparam int TBL_NUM = SEGMENT_NUM << BIN_WIDTH;
	localparam int REF_IW = $clog2(REF_PARTICLE_NUM);

	logic clk = 1'b0;
	logic rst_n, psel, penable, pwrite, pready, pslverr, force_valid, done;
	logic [lj_cfg_pkg::apb_addr_w-1:0] paddr;
	logic [lj_cfg_pkg::apb_data_w-1:0] pwdata, prdata;
	lj_num_pkg::force_t force_x, force_y, force_z;
	logic [REF_IW-1:0] force_ref;

	int errors = 0;
	int checks = 0;
	int limit_ns = 0; // watchdog armed once nonzero
	int valid_cnt, done_cnt, valid_at_done, n_exp;
	int seen [REF_PARTICLE_NUM];
	int exp_x [REF_PARTICLE_NUM], exp_y [REF_PARTICLE_NUM], exp_z [REF_PARTICLE_NUM];
	int got_x [REF_PARTICLE_NUM], got_y [REF_PARTICLE_NUM], got_z [REF_PARTICLE_NUM];
	logic [31:0] ref_words [$], nbr_words [$], tbl_words [$];
	int tbl_idx [$];
	bit stim_ok;

	lj_pipeline_top #(
		.REF_PARTICLE_NUM(REF_PARTICLE_NUM),
		.NEIGHBOR_PARTICLE_NUM(NEIGHBOR_PARTICLE_NUM),
		.SEGMENT_NUM(SEGMENT_NUM),
		.BIN_WIDTH(BIN_WIDTH),
		.CUTOFF_2(20'd40000)
	) i_lj_pipeline_top (
		.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .force_x(force_x), .force_y(force_y), .force_z(force_z),
		.force_ref(force_ref), .force_valid(force_valid), .done(done)
	);

	always #5 clk = ~clk; // 10 ns period

	// outputs hold only for one cycle, catch them mid cycle
	always @(negedge clk) begin
		if (force_valid) begin
			valid_cnt++;
			seen[force_ref]++;
			got_x[force_ref] = force_x;
			got_y[force_ref] = force_y;
			got_z[force_ref] = force_z;
		end
		if (done) begin
			done_cnt++;
			valid_at_done = valid_cnt;
		end
	end

	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("watchdog: tile did not finish within %0d ns, run stopped", limit_ns);
		$display("SIMULATION FAILED");
		$finish;
	end

	task automatic check_val(input string name, input logic signed [63:0] expected,
		input logic signed [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	function automatic logic [13:0] word_addr(input lj_cfg_pkg::apb_region_e region,
		input int idx);
		return {region, 10'(idx), 2'b00}; // region in 13:12, word index in 11:2
	endfunction

	function automatic logic [31:0] pos_word(input int x, input int y, input int z);
		return {2'b00, 10'(x), 10'(y), 10'(z)};
	endfunction

	// setup phase, access phase, outputs taken before the closing edge
	task automatic apb_xfer(input logic wr, input logic [13:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err, output logic rdy);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		rdata = prdata;
		err = pslverr;
		rdy = pready;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input string name, input logic [13:0] addr, input logic [31:0] data,
		input logic exp_err);
		logic [31:0] rd;
		logic err;
		logic rdy;
		apb_xfer(1'b1, addr, data, rd, err, rdy);
		check_val({name, " pready"}, 1'b1, rdy); // zero wait states
		check_val({name, " pslverr"}, exp_err, err);
	endtask

	task automatic apb_read(input string name, input logic [13:0] addr,
		input logic [31:0] exp_data, input logic exp_err);
		logic [31:0] rd;
		logic err;
		logic rdy;
		apb_xfer(1'b0, addr, 32'h0, rd, err, rdy);
		check_val({name, " pready"}, 1'b1, rdy);
		check_val({name, " prdata"}, exp_data, rd);
		check_val({name, " pslverr"}, exp_err, err);
	endtask

	task automatic load_stim();
		int fd, a, b, c;
		string line;
		byte tag;
		n_exp = 0;
		fd = $fopen("lj_pipeline_stim.txt", "r");
		stim_ok = fd != 0;
		if (stim_ok) begin
			while ($fgets(line, fd) > 0) begin
				tag = line.getc(0); // comment and blank lines fall through
				if (tag == "R" || tag == "N" || tag == "T" || tag == "E") begin
					void'($sscanf(line.substr(1, line.len() - 1), "%d %d %d", a, b, c));
					case (tag)
						"R": ref_words.push_back(pos_word(a, b, c));
						"N": nbr_words.push_back(pos_word(a, b, c));
						"T": begin
							tbl_idx.push_back(a);
							tbl_words.push_back({16'(b), 16'(c)}); // c0 high, c1 low
						end
						default: begin
							if (n_exp < REF_PARTICLE_NUM) begin
								exp_x[n_exp] = a;
								exp_y[n_exp] = b;
								exp_z[n_exp] = c;
							end
							n_exp++;
						end
					endcase
				end
			end
			$fclose(fd);
		end
		stim_ok = stim_ok && ref_words.size() == REF_PARTICLE_NUM &&
			nbr_words.size() == NEIGHBOR_PARTICLE_NUM && n_exp == REF_PARTICLE_NUM;
	endtask

	task automatic run_and_check(input string name);
		valid_cnt = 0;
		done_cnt = 0;
		valid_at_done = 0;
		foreach (seen[i])
			seen[i] = 0;
		apb_write({name, " start"}, word_addr(lj_cfg_pkg::region_reg, 0), 32'h1, 1'b0);
		apb_read({name, " status busy"}, word_addr(lj_cfg_pkg::region_reg, 1), 32'h1, 1'b0);
		apb_read({name, " ctrl busy"}, word_addr(lj_cfg_pkg::region_reg, 0), 32'h1, 1'b0);
		// RAMs frozen mid run, so this must bounce
		apb_write({name, " ref write busy"}, word_addr(lj_cfg_pkg::region_ref, 0),
			pos_word(100, 100, 100), 1'b1);
		while (done_cnt == 0)
			@(negedge clk);
		repeat (2 * NEIGHBOR_PARTICLE_NUM) @(posedge clk); // no stray pulses after done
		check_val({name, " done pulses"}, 1, done_cnt);
		check_val({name, " force_valid before done"}, REF_PARTICLE_NUM, valid_at_done);
		check_val({name, " force_valid total"}, REF_PARTICLE_NUM, valid_cnt);
		for (int i = 0; i < REF_PARTICLE_NUM; i++) begin
			check_val($sformatf("%s ref %0d seen", name, i), 1, seen[i]);
			check_val($sformatf("%s ref %0d fx", name, i), exp_x[i], got_x[i]);
			check_val($sformatf("%s ref %0d fy", name, i), exp_y[i], got_y[i]);
			check_val($sformatf("%s ref %0d fz", name, i), exp_z[i], got_z[i]);
		end
		apb_read({name, " status done"}, word_addr(lj_cfg_pkg::region_reg, 1), 32'h2, 1'b0);
	endtask

	initial begin
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		load_stim();
		// three cycles per APB transfer, two runs, plus slack
		limit_ns = (3 * (ref_words.size() + nbr_words.size() + tbl_words.size() + 16) +
			2 * REF_PARTICLE_NUM * NEIGHBOR_PARTICLE_NUM + 200) * 10;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		if (stim_ok) begin
			@(negedge clk);
			check_val("reset force_valid", 0, force_valid);
			check_val("reset done", 0, done);
			apb_read("reset status", word_addr(lj_cfg_pkg::region_reg, 1), 32'h0, 1'b0);
			foreach (ref_words[i])
				apb_write("load ref", word_addr(lj_cfg_pkg::region_ref, i), ref_words[i], 1'b0);
			foreach (nbr_words[i])
				apb_write("load nbr", word_addr(lj_cfg_pkg::region_nbr, i), nbr_words[i], 1'b0);
			foreach (tbl_words[i])
				apb_write("load table", word_addr(lj_cfg_pkg::region_coef, tbl_idx[i]),
					tbl_words[i], 1'b0);
			apb_read("unmapped read", word_addr(lj_cfg_pkg::region_reg, 2), 32'h0, 1'b1);
			apb_write("table index beyond size", word_addr(lj_cfg_pkg::region_coef, TBL_NUM),
				32'h1234, 1'b1);
			run_and_check("run 1");
			run_and_check("run 2"); // rejected write must leave results unchanged
		end else begin
			errors++;
			$display(
				"stim file lj_pipeline_stim.txt is missing or lacks %0d R, %0d N and %0d E lines",
				REF_PARTICLE_NUM, NEIGHBOR_PARTICLE_NUM, REF_PARTICLE_NUM);
		end
		$display("errors: %0d of %0d checks failed", errors, checks);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- compile.f
lj_cfg_pkg.sv
lj_num_pkg.sv
lj_pipe_if.sv
lj_apb_loader.sv
lj_pair_gen.sv
lj_force_pipe.sv
lj_force_accum.sv
lj_pipeline_top.sv
lj_pipeline_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = lj_pipeline_tb
FILELIST = compile.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -Wno-fatal --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "sim: failure reported in $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "sim: run ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- lj_pipeline_stim.txt
# R x y z = reference position, N x y z = neighbor position (signed decimal)
# T idx c0 c1 = coefficient table entry, E fx fy fz = expected force per reference
R 0 0 0
R 6 8 0
R 300 0 50
R -400 -200 0
N 0 0 0
N 20 5 3
N 400 0 0
N -400 0 0
N 0 400 0
N 0 -400 0
T 0 1500 -100
T 1 1400 -120
T 2 1300 -110
T 3 1200 -256
T 4 800 -180
T 5 600 -200
T 6 900 -300
T 7 500 -90
T 40 -10 -4
T 41 -20 -6
T 42 -28 8
T 43 -34 12
T 44 -40 24
T 45 -42 10
T 46 -44 6
T 47 -45 3
E -39 -10 -6
E -11 44 -9
E 14 0 -8
E 0 0 0
